/* build.f */
source/dmem_pkg.sv
source/store_merge.sv
source/backing_ram.sv
source/block_cache.sv
source/data_memory.sv
verification/data_memory_assertions.sv
verification/data_memory_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the data-memory testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module data_memory_tb \
    --Mdir obj_dir \
    -o data_memory_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/data_memory_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Everything OK" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* source/backing_ram.sv */
// Backing RAM
// Byte-addressed main memory, byte-enable writes on the clock edge and
// a combinational read of the whole four-word block holding the address
`timescale 1ns/1ps
`default_nettype none

module backing_ram #(
    parameter int ADDR_WIDTH     = 32, // Byte-address width
    parameter int RAM_BYTES_LOG2 = 12  // log2 of the RAM size in bytes
) (
    input  logic               clk,
    input  dmem_pkg::addr_t    addr,      // Byte address of the access
    input  dmem_pkg::word_t    lane_data, // Lane-aligned store data
    input  dmem_pkg::byte_en_t byte_en,   // Lanes to write, zero when idle
    output dmem_pkg::block_t   ram_block  // Aligned block containing addr
);

    // The RAM cannot be bigger than the address space
    localparam int IDX_BITS = (RAM_BYTES_LOG2 < ADDR_WIDTH) ? RAM_BYTES_LOG2 : ADDR_WIDTH;
    localparam int RAM_BYTES = 2 ** IDX_BITS;

    logic [7:0] mem [RAM_BYTES]; // Byte storage, not cleared by reset

    logic [IDX_BITS-5:0] blk_idx;  // Block number inside the RAM
    logic [IDX_BITS-3:0] word_idx; // Word number inside the RAM

    assign blk_idx  = addr[IDX_BITS-1:4]; // Upper address bits alias
    assign word_idx = addr[IDX_BITS-1:2];

    // Write the enabled lanes of the aligned word
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
                mem[{word_idx, 2'(i)}] <= lane_data[8*i +: 8];
            end
        end
    end

    // Block read, 16 bytes, little-endian inside each word
    for (genvar w = 0; w < 4; w++) begin : g_word
        for (genvar b = 0; b < 4; b++) begin : g_byte
            assign ram_block[32*w + 8*b +: 8] = mem[{blk_idx, 2'(w), 2'(b)}];
        end
    end

endmodule

`default_nettype wire

/* source/block_cache.sv */
// Direct-mapped block cache
// Valid, tag and four-word data per line. Read hits come from the line,
// read misses come from the RAM block and fill the whole line at the next edge.
// Stores allocate the line with the RAM block and the store merged in.
`timescale 1ns/1ps
`default_nettype none

module block_cache #(
    parameter int ADDR_WIDTH = 32, // Byte-address width
    parameter int SET_BITS   = 4   // log2 of the number of lines
) (
    input  logic               clk,
    input  logic               rst_n,     // Synchronous, clears valid bits
    input  logic               re,        // Read in this cycle
    input  logic               we,        // Store in this cycle
    input  dmem_pkg::addr_t    addr,      // Byte address
    input  dmem_pkg::block_t   ram_block, // Block from the backing RAM
    input  dmem_pkg::word_t    lane_data, // Lane-aligned store data
    input  dmem_pkg::byte_en_t byte_en,   // Lanes written by the store
    output dmem_pkg::word_t    rdata,     // Read word
    output logic               miss       // Read found no valid line
);

    localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - 4; // Above set and block offset
    localparam int LINES    = 2 ** SET_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [SET_BITS-1:0] set_t;

    // Line storage
    logic             valid [LINES]; // Cleared by reset
    tag_t             tag_mem [LINES];
    dmem_pkg::block_t data_mem [LINES];

    // Address fields
    set_t       set;
    tag_t       tag;
    logic [1:0] word_off; // Word within the block

    logic             hit;
    dmem_pkg::block_t src_block;   // Block that feeds rdata
    dmem_pkg::block_t store_block; // RAM block with the store merged in

    assign set      = addr[SET_BITS+3:4];
    assign tag      = addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign word_off = addr[3:2];

    // Lookup
    assign hit       = valid[set] && (tag_mem[set] == tag);
    assign src_block = hit ? data_mem[set] : ram_block; // Miss served straight from RAM
    assign rdata     = src_block[{word_off, 5'b00000} +: 32];
    assign miss      = re && !hit; // Only meaningful during a read

    // Replace the enabled lanes of the addressed word,
    // the other three words keep their RAM value
    always_comb begin
        store_block = ram_block;
        for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
                store_block[{word_off, 2'(i), 3'b000} +: 8] = lane_data[8*i +: 8];
            end
        end
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < LINES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (we || miss) begin
            valid[set] <= 1'b1; // Store allocates, read miss fills
        end
    end

    // Tag and data, same edge as the RAM write
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[set]  <= tag;
            data_mem[set] <= store_block; // Write-allocate with merge
        end else if (miss) begin
            tag_mem[set]  <= tag;
            data_mem[set] <= ram_block;   // Spatial fill, all four words
        end
    end

endmodule

`default_nettype wire

/* source/data_memory.sv */
// Data-memory subsystem top
// Store alignment, write-through backing RAM and direct-mapped block cache,
// one access per clock with no stall
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int ADDR_WIDTH     = dmem_pkg::ADDR_WIDTH,
    parameter int SET_BITS       = dmem_pkg::SET_BITS,
    parameter int RAM_BYTES_LOG2 = dmem_pkg::RAM_BYTES_LOG2
) (
    input  logic             clk,
    input  logic             rst_n, // Synchronous, active low
    input  logic             re,    // Load
    input  logic             we,    // Store
    input  dmem_pkg::addr_t  addr,  // Byte address
    input  dmem_pkg::size_t  size,  // Store size code
    input  dmem_pkg::word_t  wdata, // Store data
    output dmem_pkg::word_t  rdata, // Aligned load word
    output logic             miss   // Load missed the cache
);

    dmem_pkg::word_t    lane_data; // Store data on its lanes
    dmem_pkg::byte_en_t byte_en;   // Shared by RAM and cache
    dmem_pkg::block_t   ram_block; // Block holding addr

    store_merge i_store_merge (
        .we        (we),
        .size      (size),
        .offset    (addr[1:0]),
        .wdata     (wdata),
        .lane_data (lane_data),
        .byte_en   (byte_en)
    );

    backing_ram #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .RAM_BYTES_LOG2 (RAM_BYTES_LOG2)
    ) i_backing_ram (
        .clk       (clk),
        .addr      (addr),
        .lane_data (lane_data),
        .byte_en   (byte_en),
        .ram_block (ram_block)
    );

    block_cache #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .SET_BITS   (SET_BITS)
    ) i_block_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .re        (re),
        .we        (we),
        .addr      (addr),
        .ram_block (ram_block),
        .lane_data (lane_data),
        .byte_en   (byte_en),
        .rdata     (rdata),
        .miss      (miss)
    );

endmodule

`default_nettype wire

/* source/dmem_pkg.sv */
// Data-memory shared definitions
// Default geometry, typed vectors for addresses, words and blocks,
// and the store-size codes used by the processor interface
`default_nettype none

package dmem_pkg;

    // Default geometry, overridable from the top level
    localparam int ADDR_WIDTH     = 32; // Byte-address width
    localparam int SET_BITS       = 4;  // 16 cache lines
    localparam int RAM_BYTES_LOG2 = 12; // 4 KB backing RAM, higher addresses alias

    // Byte address as seen by the processor
    typedef logic [31:0] addr_t;

    // One data word
    typedef logic [31:0] word_t;

    // Per-lane write enable, bit 0 is the least significant byte
    typedef logic [3:0] byte_en_t;

    // Four words of one cache block, word 0 in the low bits
    typedef logic [127:0] block_t;

    // Store size
    typedef logic [1:0] size_t;

    // Store-size codes as the processor encodes them
    localparam size_t SIZE_WORD = 2'b00;
    localparam size_t SIZE_BYTE = 2'b01;
    localparam size_t SIZE_HALF = 2'b10;
    // Code 2'b11 is not a valid size and writes nothing

endpackage

`default_nettype wire

/* source/store_merge.sv */
// Store lane alignment
// Places store data on the byte lanes named by size and byte offset
// and raises the matching byte enables
`timescale 1ns/1ps
`default_nettype none

module store_merge (
    input  logic              we,        // Store in this cycle
    input  dmem_pkg::size_t   size,      // Word, byte or halfword
    input  logic [1:0]        offset,    // Byte offset within the word
    input  dmem_pkg::word_t   wdata,     // Store data, right aligned
    output dmem_pkg::word_t   lane_data, // Data replicated onto the lanes
    output dmem_pkg::byte_en_t byte_en   // Lanes to write
);

    dmem_pkg::byte_en_t lane_sel; // Lanes picked by size and offset

    always_comb begin
        case (size)
            dmem_pkg::SIZE_WORD: begin
                lane_data = wdata;
                lane_sel  = 4'b1111;
            end
            dmem_pkg::SIZE_HALF: begin
                lane_data = {2{wdata[15:0]}};                // Same half in both positions
                lane_sel  = offset[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
            end
            dmem_pkg::SIZE_BYTE: begin
                lane_data = {4{wdata[7:0]}};                 // Byte on every lane
                lane_sel  = 4'b0001 << offset;
            end
            default: begin
                // Invalid size, nothing is written
                lane_data = wdata;
                lane_sel  = 4'b0000;
            end
        endcase
    end

    // No enables at all outside a store
    assign byte_en = we ? lane_sel : 4'b0000;

endmodule

`default_nettype wire

/* verification/data_memory_assertions.sv */
// Data-memory assertions
// Bound into the block cache, checks strobe exclusivity, store alignment
// and that a line filled by a read miss hits on the next read
`timescale 1ns/1ps
`default_nettype none

module data_memory_assertions (
    input logic               clk,
    input logic               rst_n,
    input logic               re,
    input logic               we,
    input dmem_pkg::addr_t    addr,
    input dmem_pkg::byte_en_t byte_en, // Nonzero only during a store
    input logic               miss
);

    logic            prev_miss; // Read missed in the last cycle
    dmem_pkg::addr_t prev_addr; // Address of that read

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev_miss <= 1'b0; // Reset also clears the line
        end else begin
            prev_miss <= re && miss;
        end
        prev_addr <= addr;
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n) !(re && we))
        else $error("re and we high in the same cycle");

    // All four lanes enabled means a word store
    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (byte_en == 4'b1111) |-> (addr[1:0] == 2'b00))
        else $error("word store with nonzero byte offset");

    // Two lanes enabled means a halfword store
    a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (byte_en == 4'b0011 || byte_en == 4'b1100) |-> (addr[0] == 1'b0))
        else $error("halfword store at an odd address");

    a_fill_hits: assert property (@(posedge clk) disable iff (!rst_n)
        (prev_miss && re && addr == prev_addr) |-> !miss)
        else $error("read after a fill missed again");

endmodule

bind block_cache data_memory_assertions i_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .re      (re),
    .we      (we),
    .addr    (addr),
    .byte_en (byte_en),
    .miss    (miss)
);

`default_nettype wire

/* verification/data_memory_tb.sv */
// Data-memory testbench
// Table of stores, loads, idles and resets applied to the cached data memory,
// expected words built from the byte-merge rule of the store sizes
`timescale 1ns/1ps
`default_nettype none

module data_memory_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;

    typedef struct packed {
        logic            rst;       // Hold reset during this row
        logic            re;
        logic            we;
        dmem_pkg::addr_t addr;
        dmem_pkg::size_t size;
        dmem_pkg::word_t wdata;
        dmem_pkg::word_t exp_rdata; // Checked on read rows only
        logic            exp_miss;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            re;
    logic            we;
    dmem_pkg::addr_t addr;
    dmem_pkg::size_t size;
    dmem_pkg::word_t wdata;
    dmem_pkg::word_t rdata;
    logic            miss;

    row_t rows[$]; // Stimulus table
    int   seed;
    int   errors;
    int   checks;
    logic table_ready;

    data_memory i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .re    (re),
        .we    (we),
        .addr  (addr),
        .size  (size),
        .wdata (wdata),
        .rdata (rdata),
        .miss  (miss)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Old word with the lanes of one store replaced
    function automatic dmem_pkg::word_t apply_store(input dmem_pkg::word_t old,
            input dmem_pkg::size_t sz, input logic [1:0] off, input dmem_pkg::word_t data);
        dmem_pkg::word_t res;
        res = old;
        case (sz)
            dmem_pkg::SIZE_WORD: res = data;
            dmem_pkg::SIZE_HALF: begin
                if (off[1]) res[31:16] = data[15:0]; // Upper half
                else        res[15:0]  = data[15:0];
            end
            dmem_pkg::SIZE_BYTE: begin
                case (off)
                    2'd0:    res[7:0]   = data[7:0];
                    2'd1:    res[15:8]  = data[7:0];
                    2'd2:    res[23:16] = data[7:0];
                    default: res[31:24] = data[7:0];
                endcase
            end
            default: res = old; // Code 11 stores nothing
        endcase
        return res;
    endfunction

    function automatic void store_row(input dmem_pkg::addr_t a, input dmem_pkg::size_t sz,
            input dmem_pkg::word_t d);
        row_t r;
        r       = '0;
        r.we    = 1'b1;
        r.addr  = a;
        r.size  = sz;
        r.wdata = d;
        rows.push_back(r); // A store never raises miss
    endfunction

    function automatic void read_row(input dmem_pkg::addr_t a, input dmem_pkg::word_t exp,
            input logic exp_miss);
        row_t r;
        r           = '0;
        r.re        = 1'b1;
        r.addr      = a;
        r.exp_rdata = exp;
        r.exp_miss  = exp_miss;
        rows.push_back(r);
    endfunction

    function automatic void idle_row(input dmem_pkg::addr_t a);
        row_t r;
        r      = '0;
        r.addr = a; // Address moves, miss must stay low
        rows.push_back(r);
    endfunction

    function automatic void reset_row();
        row_t r;
        r     = '0;
        r.rst = 1'b1;
        rows.push_back(r);
    endfunction

    task automatic build_table();
        dmem_pkg::word_t rnd [8]; // Data of the word stores
        dmem_pkg::word_t w;
        for (int i = 0; i < 8; i++) begin
            rnd[i] = $random(seed);
        end
        // Store allocates, then read hits, after reset read misses from RAM
        store_row(32'h040, dmem_pkg::SIZE_WORD, rnd[0]);
        read_row(32'h040, rnd[0], 1'b0);
        read_row(32'h040, rnd[0], 1'b0);
        reset_row();
        read_row(32'h040, rnd[0], 1'b1);
        read_row(32'h040, rnd[0], 1'b0);
        // Byte and halfword merges into a known word
        w = rnd[1];
        store_row(32'h080, dmem_pkg::SIZE_WORD, w);
        read_row(32'h080, w, 1'b0);
        store_row(32'h081, dmem_pkg::SIZE_BYTE, 32'h1234_56a5);
        w = apply_store(w, dmem_pkg::SIZE_BYTE, 2'd1, 32'h1234_56a5);
        read_row(32'h080, w, 1'b0);
        store_row(32'h082, dmem_pkg::SIZE_HALF, 32'hbeef_c0de);
        w = apply_store(w, dmem_pkg::SIZE_HALF, 2'd2, 32'hbeef_c0de);
        read_row(32'h080, w, 1'b0);
        store_row(32'h080, dmem_pkg::SIZE_HALF, 32'h7777_1234);
        w = apply_store(w, dmem_pkg::SIZE_HALF, 2'd0, 32'h7777_1234);
        read_row(32'h080, w, 1'b0);
        store_row(32'h083, dmem_pkg::SIZE_BYTE, 32'h0000_005a);
        w = apply_store(w, dmem_pkg::SIZE_BYTE, 2'd3, 32'h0000_005a);
        read_row(32'h080, w, 1'b0);
        reset_row();
        read_row(32'h080, w, 1'b1); // Write-through reached the RAM
        // Spatial fill of block 0x0c0 from a read of word 2
        store_row(32'h0c0, dmem_pkg::SIZE_WORD, rnd[2]);
        store_row(32'h0c4, dmem_pkg::SIZE_WORD, rnd[3]);
        store_row(32'h0c8, dmem_pkg::SIZE_WORD, rnd[4]);
        store_row(32'h0cc, dmem_pkg::SIZE_WORD, rnd[5]);
        reset_row();
        read_row(32'h0c8, rnd[4], 1'b1);
        read_row(32'h0c0, rnd[2], 1'b0);
        read_row(32'h0c4, rnd[3], 1'b0);
        read_row(32'h0cc, rnd[5], 1'b0);
        // Set 1 with tags 1 and 2, each read evicts the other
        store_row(32'h110, dmem_pkg::SIZE_WORD, rnd[6]);
        store_row(32'h210, dmem_pkg::SIZE_WORD, rnd[7]);
        read_row(32'h110, rnd[6], 1'b1);
        read_row(32'h210, rnd[7], 1'b1);
        read_row(32'h110, rnd[6], 1'b1);
        read_row(32'h210, rnd[7], 1'b1);
        // Idle cycles and an invalid store size
        idle_row(32'h300);
        idle_row(32'h310);
        store_row(32'h040, 2'b11, 32'hdead_beef);
        read_row(32'h040, rnd[0], 1'b0); // Line allocated from unchanged RAM
        reset_row();
        idle_row(32'h040);
        read_row(32'h040, rnd[0], 1'b1);
    endtask

    task automatic apply_row(input row_t r);
        rst_n = !r.rst;
        re    = r.re;
        we    = r.we;
        addr  = r.addr;
        size  = r.size;
        wdata = r.wdata;
    endtask

    task automatic check_word(input string name, input int row,
            input dmem_pkg::word_t expected, input dmem_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0d ns, row %0d: %s expected %h, got %h",
                     $time, row, name, expected, actual);
        end
    endtask

    task automatic check_miss(input int row, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0d ns, row %0d: miss expected %b, got %b",
                     $time, row, expected, actual);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        re          = 1'b0;
        we          = 1'b0;
        addr        = '0;
        size        = dmem_pkg::SIZE_WORD;
        wdata       = '0;
        seed        = 6567;
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            apply_row(rows[i]);
            #1; // Outputs settled, well before the next rising edge
            if (!rows[i].rst) begin
                check_miss(i, rows[i].exp_miss, miss);
                if (rows[i].re) check_word("rdata", i, rows[i].exp_rdata, rdata);
            end
        end
        @(negedge clk);
        re = 1'b0;
        we = 1'b0;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog, sized from the table length
    initial begin
        wait (table_ready === 1'b1);
        #((rows.size() + 20) * CLK_PERIOD);
        $display("Timeout: the stimulus table did not complete in time");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
